// File: verif/fpu_tests.txt
# i0_valid i0_stall i0_ctrl i0_rs1 i0_rs2 i1_valid i1_stall i1_ctrl i1_rs1 i1_rs2 lx_cycles
# then mis_valid mis_result mis_flags mv_valid mv_result, every field in hex
1 0 12 3f800000 3f800000 0 0 00 00000000 00000000 0 1 00000001 00 0 00000000
1 0 13 c0000000 bf800000 0 0 00 00000000 00000000 0 1 00000001 00 0 00000000
1 0 14 40000000 3f800000 0 0 00 00000000 00000000 0 1 00000000 00 0 00000000
1 0 12 00000000 80000000 0 0 00 00000000 00000000 0 1 00000001 00 0 00000000
1 0 13 80000000 00000000 0 0 00 00000000 00000000 0 1 00000000 00 0 00000000
1 0 12 7fc00000 3f800000 0 0 00 00000000 00000000 0 1 00000000 00 0 00000000
1 0 12 7f800001 3f800000 0 0 00 00000000 00000000 0 1 00000000 10 0 00000000
1 0 13 7fc00000 3f800000 0 0 00 00000000 00000000 0 1 00000000 10 0 00000000
1 0 10 7fc00000 40000000 0 0 00 00000000 00000000 0 1 40000000 00 0 00000000
1 0 11 3f800000 7f800001 0 0 00 00000000 00000000 0 1 3f800000 10 0 00000000
1 0 10 7fc00000 7f800001 0 0 00 00000000 00000000 0 1 7fc00000 10 0 00000000
1 0 11 7fc00000 7fc00000 0 0 00 00000000 00000000 0 1 7fc00000 00 0 00000000
1 0 10 00000000 80000000 0 0 00 00000000 00000000 0 1 80000000 00 0 00000000
1 0 11 80000000 00000000 0 0 00 00000000 00000000 0 1 00000000 00 0 00000000
1 0 15 ff800000 00000000 0 0 00 00000000 00000000 0 1 00000001 00 0 00000000
1 0 15 bf800000 00000000 0 0 00 00000000 00000000 0 1 00000002 00 0 00000000
1 0 15 80000001 00000000 0 0 00 00000000 00000000 0 1 00000004 00 0 00000000
1 0 15 80000000 00000000 0 0 00 00000000 00000000 0 1 00000008 00 0 00000000
1 0 15 00000000 00000000 0 0 00 00000000 00000000 0 1 00000010 00 0 00000000
1 0 15 00000001 00000000 0 0 00 00000000 00000000 0 1 00000020 00 0 00000000
1 0 15 3f800000 00000000 0 0 00 00000000 00000000 0 1 00000040 00 0 00000000
1 0 15 7f800000 00000000 0 0 00 00000000 00000000 0 1 00000080 00 0 00000000
1 0 15 7f800001 00000000 0 0 00 00000000 00000000 0 1 00000100 00 0 00000000
1 0 15 7fc00000 00000000 0 0 00 00000000 00000000 0 1 00000200 00 0 00000000
1 0 08 3f800000 c0000000 0 0 00 00000000 00000000 0 0 00000000 00 1 bf800000
1 0 09 bf800000 c0000000 0 0 00 00000000 00000000 0 0 00000000 00 1 3f800000
1 0 0a bf800000 c0000000 0 0 00 00000000 00000000 0 0 00000000 00 1 3f800000
1 0 0b c0400000 3f800000 0 0 00 00000000 00000000 0 0 00000000 00 1 c0400000
1 0 12 3f800000 3f800000 1 0 09 40000000 00000000 0 1 00000001 00 1 c0000000
1 0 11 3f800000 40000000 1 0 10 3f800000 40000000 0 1 40000000 00 0 00000000
1 1 0b 12345678 00000000 0 0 00 00000000 00000000 0 0 00000000 00 0 00000000
1 1 10 3f800000 40000000 1 0 13 3f800000 40000000 0 1 00000001 00 0 00000000
1 0 0b 40400000 00000000 1 0 14 bf800000 bf800000 3 1 00000001 00 1 40400000
0 0 00 00000000 00000000 1 0 15 40400000 00000000 2 1 00000040 00 0 00000000

// File: all.f
logic/fpu_pkg.sv
logic/fpu_op_if.sv
logic/fpu_issue_decode.sv
logic/fpu_compare_unit.sv
logic/fpu_move_unit.sv
logic/fpu_result_stage.sv
logic/fpu_top.sv
verif/fpu_top_chk.sv
verif/fpu_top_tb.sv

// File: Bender.yml
package:
  name: fpu_dispatch

sources:
  - files:
      - logic/fpu_pkg.sv
      - logic/fpu_op_if.sv
      - logic/fpu_issue_decode.sv
      - logic/fpu_compare_unit.sv
      - logic/fpu_move_unit.sv
      - logic/fpu_result_stage.sv
      - logic/fpu_top.sv
  - target: test
    files:
      - verif/fpu_top_chk.sv
      - verif/fpu_top_tb.sv

// File: verif/fpu_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_top_tb
	import fpu_pkg::*;
();

	logic              core_clk;
	logic              core_reset_n;
	logic              i0_valid;
	logic              i0_stall;
	logic [CTRL_W-1:0] i0_ctrl;
	logic [FLEN-1:0]   i0_rs1;
	logic [FLEN-1:0]   i0_rs2;
	logic              i1_valid;
	logic              i1_stall;
	logic [CTRL_W-1:0] i1_ctrl;
	logic [FLEN-1:0]   i1_rs1;
	logic [FLEN-1:0]   i1_rs2;
	logic              lx_stall;
	logic [FLEN-1:0]   mis_result;
	logic [FLAG_W-1:0] mis_flags;
	logic              mis_valid;
	logic [FLEN-1:0]   mv_result;
	logic              mv_valid;
	logic              standby_ready;

	string test_lines[$];
	int    seed;
	int    error_count = 0;
	int    passed_count = 0;
	int    cycle_count = 0;
	int    cycle_limit = 0;

	fpu_top dut_i (.*);

	bind fpu_top fpu_top_chk chk_i (
		.core_clk      (core_clk),
		.core_reset_n  (core_reset_n),
		.i0_valid      (i0_valid),
		.i0_stall      (i0_stall),
		.i0_ctrl       (i0_ctrl),
		.i1_valid      (i1_valid),
		.i1_stall      (i1_stall),
		.i1_ctrl       (i1_ctrl),
		.lx_stall      (lx_stall),
		.mis_result    (mis_result),
		.mis_flags     (mis_flags),
		.mis_valid     (mis_valid),
		.mv_result     (mv_result),
		.mv_valid      (mv_valid),
		.standby_ready (standby_ready)
	);

	always #10 core_clk = ~core_clk;  // 20 ns period

	always @(posedge core_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("run stopped after %0d cycles, the test list did not finish", cycle_count);
			$display("tests failed");
			$finish;
		end
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////
	task automatic load_tests(output bit ok);
		int    fd;
		string line;
		fd = $fopen("verif/fpu_tests.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line.getc(0) != "#")  // Skip header and blanks
					test_lines.push_back(line);
			end
			$fclose(fd);
		end
	endtask

	task automatic drive_inputs(input logic v0, input logic s0, input logic [CTRL_W-1:0] c0,
			input logic [FLEN-1:0] a0, input logic [FLEN-1:0] b0, input logic v1,
			input logic s1, input logic [CTRL_W-1:0] c1, input logic [FLEN-1:0] a1,
			input logic [FLEN-1:0] b1);
		i0_valid = v0;
		i0_stall = s0;
		i0_ctrl  = c0;
		i0_rs1   = a0;
		i0_rs2   = b0;
		i1_valid = v1;
		i1_stall = s1;
		i1_ctrl  = c1;
		i1_rs1   = a1;
		i1_rs2   = b1;
	endtask

	task automatic check_value(input int idx, input string what, input logic [FLEN-1:0] got,
			input logic [FLEN-1:0] exp);
		assert (got === exp) else begin
			$display("Fail at %0d ns: test %0d %s is %h, expected %h", $time, idx, what, got, exp);
			error_count++;
		end
	endtask

	task automatic run_test(input int idx, input string line);
		logic              v0, s0, v1, s1, exp_mis_v, exp_mv_v;
		logic [CTRL_W-1:0] c0, c1;
		logic [FLEN-1:0]   a0, b0, a1, b1, exp_mis, exp_mv;
		logic [FLAG_W-1:0] exp_flags;
		int                lx_cycles, fields, gap, errs_before;
		logic              busy;
		errs_before = error_count;
		fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
			v0, s0, c0, a0, b0, v1, s1, c1, a1, b1, lx_cycles,
			exp_mis_v, exp_mis, exp_flags, exp_mv_v, exp_mv);
		if (fields != 16) begin
			$display("test %0d could not be read from the data file", idx);
			error_count++;
		end else begin
			busy = exp_mis_v | exp_mv_v;
			gap = 1 + ({$random(seed)} % 2);  // Idle edges drain the last result
			repeat (gap) @(posedge core_clk);
			#1;
			check_value(idx, "standby_ready before issue", standby_ready, 1);
			drive_inputs(v0, s0, c0, a0, b0, v1, s1, c1, a1, b1);
			@(posedge core_clk);  // Captured into F1
			#1;
			drive_inputs(0, 0, '0, '0, '0, 0, 0, '0, '0, '0);
			lx_stall = (lx_cycles > 0);
			@(negedge core_clk);
			check_value(idx, "standby_ready in F1", standby_ready, !busy);
			for (int k = 0; k < lx_cycles; k++) begin
				@(posedge core_clk);
				#1;
				if (k == lx_cycles - 1)
					lx_stall = 1'b0;
				@(negedge core_clk);
				check_value(idx, "mis_valid in stall", mis_valid, 0);
				check_value(idx, "mv_valid in stall", mv_valid, 0);
				check_value(idx, "standby_ready in stall", standby_ready, !busy);
			end
			@(posedge core_clk);  // Result stage loads
			@(negedge core_clk);
			check_value(idx, "mis_valid", mis_valid, exp_mis_v);
			check_value(idx, "mv_valid", mv_valid, exp_mv_v);
			check_value(idx, "standby_ready with result", standby_ready, !busy);
			if (exp_mis_v) begin
				check_value(idx, "mis_result", mis_result, exp_mis);
				check_value(idx, "mis_flags", mis_flags, exp_flags);
			end
			if (exp_mv_v)
				check_value(idx, "mv_result", mv_result, exp_mv);
		end
		if (error_count == errs_before) begin
			passed_count++;
			$display("test %0d passed", idx);
		end else begin
			$display("test %0d had %0d errors", idx, error_count - errs_before);
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		bit loaded;
		int total_errors;
		seed = 25;
		core_clk = 1'b0;
		core_reset_n = 1'b1;
		lx_stall = 1'b0;
		drive_inputs(0, 0, '0, '0, '0, 0, 0, '0, '0, '0);
		load_tests(loaded);
		if (!loaded || test_lines.size() == 0) begin
			$display("the data file verif/fpu_tests.txt is missing or empty");
			$display("tests failed");
			$finish;
		end else begin
			cycle_limit = test_lines.size() * 8 + 20;
			#1 core_reset_n = 1'b0;
			repeat (2) @(posedge core_clk);
			#1 core_reset_n = 1'b1;
			foreach (test_lines[i])
				run_test(i + 1, test_lines[i]);
			total_errors = error_count + dut_i.chk_i.fail_count;
			$display("%0d run, %0d passed, %0d check errors, %0d assertion errors",
				test_lines.size(), passed_count, error_count, dut_i.chk_i.fail_count);
			if (total_errors == 0)
				$display("all tests passed");
			else
				$display("tests failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: verif/fpu_top_chk.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_top_chk
	import fpu_pkg::*;
(
	input logic              core_clk,
	input logic              core_reset_n,
	input logic              i0_valid,
	input logic              i0_stall,
	input logic [CTRL_W-1:0] i0_ctrl,
	input logic              i1_valid,
	input logic              i1_stall,
	input logic [CTRL_W-1:0] i1_ctrl,
	input logic              lx_stall,
	input logic [FLEN-1:0]   mis_result,
	input logic [FLAG_W-1:0] mis_flags,
	input logic              mis_valid,
	input logic [FLEN-1:0]   mv_result,
	input logic              mv_valid,
	input logic              standby_ready
);

	int   fail_count = 0;
	logic issue;

	assign issue = (i0_valid & ~i0_stall & (i0_ctrl[CTRL_MIS_BIT] | i0_ctrl[CTRL_MV_BIT]))
	             | (i1_valid & ~i1_stall & (i1_ctrl[CTRL_MIS_BIT] | i1_ctrl[CTRL_MV_BIT]));

	reset_quiet: assert property (@(posedge core_clk)
		!core_reset_n |-> (!mis_valid && !mv_valid))
		else begin
			$error("result valid raised while reset is active");
			fail_count++;
		end

	stall_holds: assert property (@(posedge core_clk) disable iff (!core_reset_n)
		lx_stall |=> $stable({mis_valid, mis_result, mis_flags, mv_valid, mv_result}))
		else begin
			$error("outputs changed across a late stall edge");
			fail_count++;
		end

	busy_after_issue: assert property (@(posedge core_clk) disable iff (!core_reset_n)
		(issue && !lx_stall) |=> !standby_ready)
		else begin
			$error("standby_ready high right after an issue");
			fail_count++;
		end

endmodule

`default_nettype wire

// File: logic/fpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_top
	import fpu_pkg::*;
(
	input  logic              core_clk,
	input  logic              core_reset_n,
	input  logic              i0_valid,
	input  logic              i0_stall,
	input  logic [CTRL_W-1:0] i0_ctrl,
	input  logic [FLEN-1:0]   i0_rs1,
	input  logic [FLEN-1:0]   i0_rs2,
	input  logic              i1_valid,
	input  logic              i1_stall,
	input  logic [CTRL_W-1:0] i1_ctrl,
	input  logic [FLEN-1:0]   i1_rs1,
	input  logic [FLEN-1:0]   i1_rs2,
	input  logic              lx_stall,
	output logic [FLEN-1:0]   mis_result,
	output logic [FLAG_W-1:0] mis_flags,
	output logic              mis_valid,
	output logic [FLEN-1:0]   mv_result,
	output logic              mv_valid,
	output logic              standby_ready
);

	logic              mis_unit_valid;
	logic [FLEN-1:0]   mis_unit_result;
	logic [FLAG_W-1:0] mis_unit_flags;
	logic              mv_unit_valid;
	logic [FLEN-1:0]   mv_unit_result;

	fpu_op_if #(.OP_W(MIS_OPS)) mis_op ();
	fpu_op_if #(.OP_W(MV_OPS))  mv_op ();

	//////////////////////////////
	// Decode into F1
	//////////////////////////////
	fpu_issue_decode u_issue_decode (
		.core_clk     (core_clk),
		.core_reset_n (core_reset_n),
		.i0_valid     (i0_valid),
		.i0_stall     (i0_stall),
		.i0_ctrl      (i0_ctrl),
		.i0_rs1       (i0_rs1),
		.i0_rs2       (i0_rs2),
		.i1_valid     (i1_valid),
		.i1_stall     (i1_stall),
		.i1_ctrl      (i1_ctrl),
		.i1_rs1       (i1_rs1),
		.i1_rs2       (i1_rs2),
		.lx_stall     (lx_stall),
		.mis_op       (mis_op.issue),
		.mv_op        (mv_op.issue)
	);

	//////////////////////////////
	// F1 execute and result
	//////////////////////////////
	fpu_compare_unit u_compare_unit (
		.op     (mis_op.exec),
		.valid  (mis_unit_valid),
		.result (mis_unit_result),
		.flags  (mis_unit_flags)
	);

	fpu_move_unit u_move_unit (
		.op     (mv_op.exec),
		.valid  (mv_unit_valid),
		.result (mv_unit_result)
	);

	fpu_result_stage u_result_stage (
		.core_clk      (core_clk),
		.core_reset_n  (core_reset_n),
		.lx_stall      (lx_stall),
		.mis_in_valid  (mis_unit_valid),
		.mis_in_result (mis_unit_result),
		.mis_in_flags  (mis_unit_flags),
		.mv_in_valid   (mv_unit_valid),
		.mv_in_result  (mv_unit_result),
		.mis_valid     (mis_valid),
		.mis_result    (mis_result),
		.mis_flags     (mis_flags),
		.mv_valid      (mv_valid),
		.mv_result     (mv_result),
		.standby_ready (standby_ready)
	);

endmodule

`default_nettype wire

// File: logic/fpu_result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_result_stage
	import fpu_pkg::*;
(
	input  logic              core_clk,
	input  logic              core_reset_n,
	input  logic              lx_stall,
	input  logic              mis_in_valid,
	input  logic [FLEN-1:0]   mis_in_result,
	input  logic [FLAG_W-1:0] mis_in_flags,
	input  logic              mv_in_valid,
	input  logic [FLEN-1:0]   mv_in_result,
	output logic              mis_valid,
	output logic [FLEN-1:0]   mis_result,
	output logic [FLAG_W-1:0] mis_flags,
	output logic              mv_valid,
	output logic [FLEN-1:0]   mv_result,
	output logic              standby_ready
);

	always_ff @(posedge core_clk or negedge core_reset_n) begin
		if (!core_reset_n) begin
			mis_valid  <= 1'b0;
			mis_result <= '0;
			mis_flags  <= '0;
			mv_valid   <= 1'b0;
			mv_result  <= '0;
		end else if (!lx_stall) begin  // Stall freezes the outputs
			mis_valid  <= mis_in_valid;
			mis_result <= mis_in_result;
			mis_flags  <= mis_in_flags;
			mv_valid   <= mv_in_valid;
			mv_result  <= mv_in_result;
		end
	end

	// Idle once F1 and this stage are both empty
	assign standby_ready = ~(mis_in_valid | mv_in_valid | mis_valid | mv_valid);

endmodule

`default_nettype wire

// File: logic/fpu_move_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_move_unit
	import fpu_pkg::*;
(
	fpu_op_if.exec          op,
	output logic            valid,
	output logic [FLEN-1:0] result
);

	logic a_sign;
	logic b_sign;
	logic inject;
	logic new_sign;

	assign a_sign = op.rs1.raw[FLEN-1];
	assign b_sign = op.rs2.raw[FLEN-1];

	assign inject = op.op[OP_FSGNJ] | op.op[OP_FSGNJN] | op.op[OP_FSGNJX];

	assign new_sign = (op.op[OP_FSGNJ] & b_sign)
	                | (op.op[OP_FSGNJN] & ~b_sign)
	                | (op.op[OP_FSGNJX] & (a_sign ^ b_sign));

	// Magnitude always comes from rs1
	assign result = ({FLEN{inject}} & {new_sign, op.rs1.raw[FLEN-2:0]})
	              | ({FLEN{op.op[OP_FMV]}} & op.rs1.raw);

	assign valid = op.valid;

endmodule

`default_nettype wire

// File: logic/fpu_compare_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_compare_unit
	import fpu_pkg::*;
(
	fpu_op_if.exec            op,
	output logic              valid,
	output logic [FLEN-1:0]   result,
	output logic [FLAG_W-1:0] flags
);

	fp_word_u           a;
	fp_word_u           b;
	logic               a_exp_max, a_exp_zero, a_man_zero;
	logic               b_exp_max, b_exp_zero, b_man_zero;
	logic               a_nan, b_nan, a_snan, b_snan;
	logic               a_zero, b_zero, a_inf, a_sub, a_norm;
	logic               both_zero, unordered;
	logic               mag_lt, mag_gt, lt, eq;
	logic               feq_res, flt_res, fle_res;
	logic               nv;
	logic [FLEN-1:0]    min_res;
	logic [FLEN-1:0]    max_res;
	logic [CLASS_W-1:0] cls_mask;

	assign a = op.rs1;
	assign b = op.rs2;

	//////////////////////////////
	// Field view: operand kinds
	//////////////////////////////
	assign a_exp_max  = (a.f.exp == 8'hff);
	assign a_exp_zero = (a.f.exp == 8'h00);
	assign a_man_zero = (a.f.man == 23'd0);
	assign b_exp_max  = (b.f.exp == 8'hff);
	assign b_exp_zero = (b.f.exp == 8'h00);
	assign b_man_zero = (b.f.man == 23'd0);

	assign a_nan  = a_exp_max & ~a_man_zero;
	assign b_nan  = b_exp_max & ~b_man_zero;
	assign a_snan = a_nan & ~a.f.man[22];  // Quiet bit clear
	assign b_snan = b_nan & ~b.f.man[22];
	assign a_zero = a_exp_zero & a_man_zero;
	assign b_zero = b_exp_zero & b_man_zero;
	assign a_inf  = a_exp_max & a_man_zero;
	assign a_sub  = a_exp_zero & ~a_man_zero;
	assign a_norm = ~a_exp_zero & ~a_exp_max;

	assign both_zero = a_zero & b_zero;
	assign unordered = a_nan | b_nan;

	//////////////////////////////
	// Raw view: ordering
	//////////////////////////////
	assign mag_lt = a.raw[FLEN-2:0] < b.raw[FLEN-2:0];
	assign mag_gt = a.raw[FLEN-2:0] > b.raw[FLEN-2:0];
	assign eq     = both_zero | (a.raw == b.raw);  // +0 == -0
	assign lt     = ~both_zero & ((a.raw[FLEN-1] != b.raw[FLEN-1]) ? a.raw[FLEN-1] :
	                              (a.raw[FLEN-1] ? mag_gt : mag_lt));

	assign feq_res = eq & ~unordered;
	assign flt_res = lt & ~unordered;
	assign fle_res = (lt | eq) & ~unordered;

	always_comb begin
		if (a_nan && b_nan) begin
			min_res = CANONICAL_NAN;
			max_res = CANONICAL_NAN;
		end else if (a_nan) begin
			min_res = b.raw;
			max_res = b.raw;
		end else if (b_nan) begin
			min_res = a.raw;
			max_res = a.raw;
		end else if (both_zero) begin
			min_res = a.f.sign ? a.raw : b.raw;  // -0 below +0
			max_res = a.f.sign ? b.raw : a.raw;
		end else begin
			min_res = lt ? a.raw : b.raw;
			max_res = lt ? b.raw : a.raw;
		end
	end

	always_comb begin
		cls_mask              = '0;
		cls_mask[CLS_NEG_INF] = a.f.sign & a_inf;
		cls_mask[CLS_NEG_NRM] = a.f.sign & a_norm;
		cls_mask[CLS_NEG_SUB] = a.f.sign & a_sub;
		cls_mask[CLS_NEG_ZER] = a.f.sign & a_zero;
		cls_mask[CLS_POS_ZER] = ~a.f.sign & a_zero;
		cls_mask[CLS_POS_SUB] = ~a.f.sign & a_sub;
		cls_mask[CLS_POS_NRM] = ~a.f.sign & a_norm;
		cls_mask[CLS_POS_INF] = ~a.f.sign & a_inf;
		cls_mask[CLS_SNAN]    = a_snan;
		cls_mask[CLS_QNAN]    = a_nan & ~a_snan;
	end

	// feq is quiet, flt and fle signal on any NaN
	assign nv = ((op.op[OP_FMIN] | op.op[OP_FMAX] | op.op[OP_FEQ]) & (a_snan | b_snan))
	          | ((op.op[OP_FLT] | op.op[OP_FLE]) & unordered);

	always_comb begin
		flags          = '0;
		flags[FLAG_NV] = nv;
		flags[FLAG_NX] = 1'b0;  // No op here rounds
	end

	assign result = ({FLEN{op.op[OP_FMIN]}} & min_res)
	              | ({FLEN{op.op[OP_FMAX]}} & max_res)
	              | {{(FLEN-1){1'b0}}, (op.op[OP_FEQ] & feq_res) | (op.op[OP_FLT] & flt_res)
	                                   | (op.op[OP_FLE] & fle_res)}
	              | ({FLEN{op.op[OP_FCLASS]}} & {{(FLEN-CLASS_W){1'b0}}, cls_mask});

	assign valid = op.valid;

endmodule

`default_nettype wire

// File: logic/fpu_issue_decode.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_issue_decode
	import fpu_pkg::*;
(
	input  logic              core_clk,
	input  logic              core_reset_n,
	input  logic              i0_valid,
	input  logic              i0_stall,
	input  logic [CTRL_W-1:0] i0_ctrl,
	input  logic [FLEN-1:0]   i0_rs1,
	input  logic [FLEN-1:0]   i0_rs2,
	input  logic              i1_valid,
	input  logic              i1_stall,
	input  logic [CTRL_W-1:0] i1_ctrl,
	input  logic [FLEN-1:0]   i1_rs1,
	input  logic [FLEN-1:0]   i1_rs2,
	input  logic              lx_stall,
	fpu_op_if.issue           mis_op,
	fpu_op_if.issue           mv_op
);

	logic                 i0_mis_req;
	logic                 i1_mis_req;
	logic                 i0_mv_req;
	logic                 i1_mv_req;
	logic                 mis_issue;
	logic                 mv_issue;
	logic [CTRL_W-1:0]    mis_ctrl;
	logic [CTRL_W-1:0]    mv_ctrl;
	logic [CTRL_OP_W-1:0] mis_code;
	logic [CTRL_OP_W-1:0] mv_code;
	logic [MIS_OPS-1:0]   mis_onehot;
	logic [MV_OPS-1:0]    mv_onehot;

	//////////////////////////////
	// F0 slot selection
	//////////////////////////////
	assign i0_mis_req = i0_valid & ~i0_stall & i0_ctrl[CTRL_MIS_BIT];
	assign i1_mis_req = i1_valid & ~i1_stall & i1_ctrl[CTRL_MIS_BIT];
	assign i0_mv_req  = i0_valid & ~i0_stall & i0_ctrl[CTRL_MV_BIT];
	assign i1_mv_req  = i1_valid & ~i1_stall & i1_ctrl[CTRL_MV_BIT];

	assign mis_issue = i0_mis_req | i1_mis_req;
	assign mv_issue  = i0_mv_req | i1_mv_req;

	assign mis_ctrl = i0_mis_req ? i0_ctrl : i1_ctrl;  // Slot 0 wins a collision
	assign mv_ctrl  = i0_mv_req ? i0_ctrl : i1_ctrl;

	assign mis_code = mis_ctrl[CTRL_OP_LSB +: CTRL_OP_W];
	assign mv_code  = mv_ctrl[CTRL_OP_LSB +: CTRL_OP_W];

	// Codes past the last op give no bit
	assign mis_onehot = (mis_code < MIS_OPS) ? ({{(MIS_OPS-1){1'b0}}, 1'b1} << mis_code) : '0;
	assign mv_onehot  = (mv_code < MV_OPS) ? ({{(MV_OPS-1){1'b0}}, 1'b1} << mv_code) : '0;

	//////////////////////////////
	// F1 registers
	//////////////////////////////
	always_ff @(posedge core_clk or negedge core_reset_n) begin
		if (!core_reset_n) begin
			mis_op.valid <= 1'b0;
			mv_op.valid  <= 1'b0;
		end else if (!lx_stall) begin
			mis_op.valid <= mis_issue;
			mv_op.valid  <= mv_issue;
		end
	end

	always_ff @(posedge core_clk or negedge core_reset_n) begin
		if (!core_reset_n) begin
			mis_op.op <= '0;
			mv_op.op  <= '0;
		end else if (!lx_stall) begin
			if (mis_issue)
				mis_op.op <= mis_onehot;
			if (mv_issue)
				mv_op.op <= mv_onehot;
		end
	end

	always_ff @(posedge core_clk) begin
		if (!lx_stall && mis_issue) begin
			mis_op.rs1 <= i0_mis_req ? i0_rs1 : i1_rs1;
			mis_op.rs2 <= i0_mis_req ? i0_rs2 : i1_rs2;
		end
		if (!lx_stall && mv_issue) begin
			mv_op.rs1 <= i0_mv_req ? i0_rs1 : i1_rs1;
			mv_op.rs2 <= i0_mv_req ? i0_rs2 : i1_rs2;
		end
	end

endmodule

`default_nettype wire

// File: logic/fpu_op_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fpu_op_if
	import fpu_pkg::*;
#(
	parameter int OP_W = MIS_OPS  // One-hot op vector width
) ();

	logic            valid;
	logic [OP_W-1:0] op;
	fp_word_u        rs1;
	fp_word_u        rs2;

	modport issue (
		output valid,
		output op,
		output rs1,
		output rs2
	);

	modport exec (
		input valid,
		input op,
		input rs1,
		input rs2
	);

endinterface

`default_nettype wire

// File: logic/fpu_pkg.sv
`default_nettype none

package fpu_pkg;

	//////////////////////////////
	// Widths and control word
	//////////////////////////////
	localparam int FLEN         = 32;
	localparam int CTRL_W       = 5;
	localparam int CTRL_MIS_BIT = 4;  // Compare unit select
	localparam int CTRL_MV_BIT  = 3;  // Move unit select
	localparam int CTRL_OP_LSB  = 0;
	localparam int CTRL_OP_W    = 3;

	// Compare unit op codes
	localparam int OP_FMIN   = 0;
	localparam int OP_FMAX   = 1;
	localparam int OP_FEQ    = 2;
	localparam int OP_FLT    = 3;
	localparam int OP_FLE    = 4;
	localparam int OP_FCLASS = 5;
	localparam int MIS_OPS   = 6;

	// Move unit op codes
	localparam int OP_FSGNJ  = 0;
	localparam int OP_FSGNJN = 1;
	localparam int OP_FSGNJX = 2;
	localparam int OP_FMV    = 3;
	localparam int MV_OPS    = 4;

	//////////////////////////////
	// Flags and classify mask
	//////////////////////////////
	localparam int FLAG_W  = 5;
	localparam int FLAG_NV = 4;  // Invalid
	localparam int FLAG_NX = 0;  // Inexact

	localparam int CLASS_W     = 10;
	localparam int CLS_NEG_INF = 0;
	localparam int CLS_NEG_NRM = 1;
	localparam int CLS_NEG_SUB = 2;
	localparam int CLS_NEG_ZER = 3;
	localparam int CLS_POS_ZER = 4;
	localparam int CLS_POS_SUB = 5;
	localparam int CLS_POS_NRM = 6;
	localparam int CLS_POS_INF = 7;
	localparam int CLS_SNAN    = 8;
	localparam int CLS_QNAN    = 9;

	localparam logic [FLEN-1:0] CANONICAL_NAN = 32'h7fc0_0000;

	// One single-precision word, raw or split into fields
	typedef union packed {
		logic [FLEN-1:0] raw;
		struct packed {
			logic        sign;
			logic [7:0]  exp;
			logic [22:0] man;
		} f;
	} fp_word_u;

endpackage

`default_nettype wire
